//--- src/periph_settings.svh
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// core bus
`define BUS_WIDTH           32
`define BUS_ACC_WIDTH       2

// access size codes, only word access is mapped
`define BUS_ACC_1B          2'd0
`define BUS_ACC_2B          2'd1
`define BUS_ACC_4B          2'd2

// address split: upper bits pick the page, lower bits the register
`define PERIPH_ADDR_WIDTH   12
`define PERIPH_VA_WIDTH     8
`define PERIPH_PAGE_WIDTH   (`PERIPH_ADDR_WIDTH - `PERIPH_VA_WIDTH)

// page numbers
`define PAGE_GPIO           0
`define PAGE_TIMER          1

// gpio
`define GPIO_WIDTH          16
`define IOR_DIR_IN          1'b1    // dir bit value meaning input

// timer
`define TIMER_EN_BIT        0       // enable bit in CTRL

`endif

//--- src/periph_pkg.sv
`include "periph_settings.svh"

package periph_pkg;

    // request as driven by the core
    typedef struct packed {
        logic                           valid;  // one cycle strobe
        logic [`PERIPH_ADDR_WIDTH-1:0]  addr;   // page + offset
        logic                           w_rb;   // 1 write, 0 read
        logic [`BUS_ACC_WIDTH-1:0]      acc;
        logic [`BUS_WIDTH-1:0]          wdata;
    } bus_req_t;

    // request as seen by one peripheral
    typedef struct packed {
        logic                           valid;
        logic [`PERIPH_VA_WIDTH-1:0]    addr;   // page offset only
        logic                           w_rb;
        logic [`BUS_ACC_WIDTH-1:0]      acc;
        logic [`BUS_WIDTH-1:0]          wdata;
    } periph_req_t;

    // response, same shape from each peripheral and out of the top
    typedef struct packed {
        logic                           resp;   // pulse one cycle after request
        logic                           fault;  // level in request cycle
        logic [`BUS_WIDTH-1:0]          rdata;  // valid with resp, held
    } bus_rsp_t;

endpackage

//--- src/periph_decoder.sv
`include "periph_settings.svh"

module periph_decoder
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,

    input  bus_req_t    bus_req,
    output bus_rsp_t    bus_rsp,

    output periph_req_t gpio_req,
    output periph_req_t timer_req,
    input  bus_rsp_t    gpio_rsp,
    input  bus_rsp_t    timer_rsp
);

    logic [`PERIPH_PAGE_WIDTH-1:0] page;
    logic [`PERIPH_VA_WIDTH-1:0]   offset;
    logic                          sel_gpio;
    logic                          sel_timer;
    logic                          page_fault;
    logic                          rd_timer_q; // last good read went to the timer

    assign page   = bus_req.addr[`PERIPH_ADDR_WIDTH-1:`PERIPH_VA_WIDTH];
    assign offset = bus_req.addr[`PERIPH_VA_WIDTH-1:0];

    assign sel_gpio  = (page == `PAGE_GPIO);
    assign sel_timer = (page == `PAGE_TIMER);

    // unmapped page is caught here, offset and size checks live in the peripherals
    assign page_fault = bus_req.valid & ~sel_gpio & ~sel_timer;

    // shared fields fan out, the strobe only to the addressed page
    always_comb begin
        gpio_req.valid  = bus_req.valid & sel_gpio;
        gpio_req.addr   = offset;
        gpio_req.w_rb   = bus_req.w_rb;
        gpio_req.acc    = bus_req.acc;
        gpio_req.wdata  = bus_req.wdata;

        timer_req.valid = bus_req.valid & sel_timer;
        timer_req.addr  = offset;
        timer_req.w_rb  = bus_req.w_rb;
        timer_req.acc   = bus_req.acc;
        timer_req.wdata = bus_req.wdata;
    end

    // read data source follows the response cycle, not the current request
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_timer_q <= 1'b0;
        end else if (bus_req.valid && !bus_req.w_rb && !bus_rsp.fault) begin
            rd_timer_q <= sel_timer;
        end
    end

    // at most one peripheral pulses resp in a cycle, so an or is enough
    assign bus_rsp.resp  = gpio_rsp.resp | timer_rsp.resp;
    assign bus_rsp.fault = page_fault | gpio_rsp.fault | timer_rsp.fault;
    assign bus_rsp.rdata = rd_timer_q ? timer_rsp.rdata : gpio_rsp.rdata;

endmodule

//--- src/gpio_controller.sv
`include "periph_settings.svh"

module gpio_controller
    import periph_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,

    input  periph_req_t             req,
    output bus_rsp_t                rsp,

    input  logic [`GPIO_WIDTH-1:0]  gpio_i,
    output logic [`GPIO_WIDTH-1:0]  gpio_o,
    output logic [`GPIO_WIDTH-1:0]  gpio_dir
);

    // register map, all word sized and R/W
    //   D    0   pins in on read, pins out on write
    //   DIR  4   1 on the bus means output
    localparam logic [`PERIPH_VA_WIDTH-1:0] off_d   = `PERIPH_VA_WIDTH'(0);
    localparam logic [`PERIPH_VA_WIDTH-1:0] off_dir = `PERIPH_VA_WIDTH'(4);
    localparam logic [`GPIO_WIDTH-1:0]      dir_in  = {`GPIO_WIDTH{`IOR_DIR_IN}};

    logic                   invld_addr;
    logic                   invld_acc;
    logic                   invld;
    logic                   acc_ok;     // valid request that passes all checks
    logic                   resp_q;
    logic [`GPIO_WIDTH-1:0] rdata_q;

    // fault checks
    assign invld_addr = (req.addr != off_d) && (req.addr != off_dir);
    assign invld_acc  = (req.acc != `BUS_ACC_4B);
    assign invld      = invld_addr | invld_acc;

    assign acc_ok    = req.valid & ~invld;
    assign rsp.fault = req.valid & invld;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp_q <= 1'b0;
        end else begin
            resp_q <= acc_ok;
        end
    end

    // read data, held until the next good read
    always_ff @(posedge clk) begin
        if (acc_ok && !req.w_rb) begin
            if (req.addr == off_d) begin
                rdata_q <= gpio_i;              // sampled in request cycle
            end else begin
                rdata_q <= gpio_dir ^ dir_in;   // back to bus polarity
            end
        end
    end

    // pin registers
    always_ff @(posedge clk) begin
        if (!rstn) begin
            gpio_o   <= '0;
            gpio_dir <= dir_in;                 // all input
        end else if (acc_ok && req.w_rb) begin
            if (req.addr == off_d) begin
                gpio_o <= req.wdata[`GPIO_WIDTH-1:0];
            end else begin
                gpio_dir <= req.wdata[`GPIO_WIDTH-1:0] ^ dir_in;
            end
        end
    end

    assign rsp.resp  = resp_q;
    assign rsp.rdata = `BUS_WIDTH'(rdata_q);   // zero extend

endmodule

//--- src/interval_timer.sv
`include "periph_settings.svh"

module interval_timer
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,

    input  periph_req_t req,
    output bus_rsp_t    rsp,

    output logic        timer_irq
);

    // register map, all word sized and R/W
    //   CTRL   0   bit 0 enable
    //   COUNT  4   running count
    //   CMP    8   match value, period is cmp + 1
    localparam logic [`PERIPH_VA_WIDTH-1:0] off_ctrl  = `PERIPH_VA_WIDTH'(0);
    localparam logic [`PERIPH_VA_WIDTH-1:0] off_count = `PERIPH_VA_WIDTH'(4);
    localparam logic [`PERIPH_VA_WIDTH-1:0] off_cmp   = `PERIPH_VA_WIDTH'(8);

    logic                  invld_addr;
    logic                  invld_acc;
    logic                  invld;
    logic                  acc_ok;
    logic                  wr_ctrl;
    logic                  wr_count;
    logic                  wr_cmp;
    logic                  match;
    logic                  resp_q;
    logic                  en_q;
    logic [`BUS_WIDTH-1:0] count_q;
    logic [`BUS_WIDTH-1:0] cmp_q;
    logic [`BUS_WIDTH-1:0] rdata_q;

    assign invld_addr = (req.addr != off_ctrl) && (req.addr != off_count) &&
                        (req.addr != off_cmp);
    assign invld_acc  = (req.acc != `BUS_ACC_4B);
    assign invld      = invld_addr | invld_acc;

    assign acc_ok    = req.valid & ~invld;
    assign rsp.fault = req.valid & invld;

    assign wr_ctrl  = acc_ok && req.w_rb && (req.addr == off_ctrl);
    assign wr_count = acc_ok && req.w_rb && (req.addr == off_count);
    assign wr_cmp   = acc_ok && req.w_rb && (req.addr == off_cmp);

    assign match = en_q && (count_q == cmp_q);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp_q    <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            resp_q    <= acc_ok;
            timer_irq <= match;     // one cycle pulse after the match
        end
    end

    // control and compare
    always_ff @(posedge clk) begin
        if (!rstn) begin
            en_q  <= 1'b0;
            cmp_q <= '0;
        end else begin
            if (wr_ctrl) en_q <= req.wdata[`TIMER_EN_BIT];
            if (wr_cmp) cmp_q <= req.wdata;
        end
    end

    // counter, a bus write wins over counting
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count_q <= '0;
        end else if (wr_count) begin
            count_q <= req.wdata;
        end else if (match) begin
            count_q <= '0;          // wrap on compare
        end else if (en_q) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_ok && !req.w_rb) begin
            case (req.addr)
                off_ctrl:  rdata_q <= `BUS_WIDTH'(en_q);
                off_count: rdata_q <= count_q;
                default:   rdata_q <= cmp_q;
            endcase
        end
    end

    assign rsp.resp  = resp_q;
    assign rsp.rdata = rdata_q;

endmodule

//--- src/periph_top.sv
`include "periph_settings.svh"

module periph_top
    import periph_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,

    input  bus_req_t                bus_req,
    output bus_rsp_t                bus_rsp,

    input  logic [`GPIO_WIDTH-1:0]  gpio_i,
    output logic [`GPIO_WIDTH-1:0]  gpio_o,
    output logic [`GPIO_WIDTH-1:0]  gpio_dir,

    output logic                    timer_irq
);

    periph_req_t gpio_req;
    periph_req_t timer_req;
    bus_rsp_t    gpio_rsp;
    bus_rsp_t    timer_rsp;

    periph_decoder i_periph_decoder (
        .clk       (clk),
        .rstn      (rstn),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .gpio_req  (gpio_req),
        .timer_req (timer_req),
        .gpio_rsp  (gpio_rsp),
        .timer_rsp (timer_rsp)
    );

    gpio_controller i_gpio_controller (
        .clk      (clk),
        .rstn     (rstn),
        .req      (gpio_req),
        .rsp      (gpio_rsp),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o),
        .gpio_dir (gpio_dir)
    );

    interval_timer i_interval_timer (
        .clk       (clk),
        .rstn      (rstn),
        .req       (timer_req),
        .rsp       (timer_rsp),
        .timer_irq (timer_irq)
    );

endmodule

//--- testbench/periph_assert.sv
`include "periph_settings.svh"

module periph_assert
    import periph_pkg::*;
(
    input logic                    clk,
    input logic                    rstn,
    input bus_req_t                bus_req,
    input bus_rsp_t                bus_rsp,
    input logic [`GPIO_WIDTH-1:0]  gpio_i,
    input logic [`GPIO_WIDTH-1:0]  gpio_o,
    input logic [`GPIO_WIDTH-1:0]  gpio_dir,
    input logic                    timer_irq
);

    localparam logic [`GPIO_WIDTH-1:0] dir_in = {`GPIO_WIDTH{`IOR_DIR_IN}};

    logic [`PERIPH_PAGE_WIDTH-1:0] page;
    logic [`PERIPH_VA_WIDTH-1:0]   off;
    logic                          legal;      // mapped page, offset and word size
    logic                          good;
    logic                          tmr_wr;
    logic                          tmr_wr_q;
    logic                          quiet;      // no timer write since the last irq
    logic [`BUS_WIDTH-1:0]         cmp_sh;     // compare value as last written
    logic [`BUS_WIDTH-1:0]         gap;        // cycles since the last irq
    logic [`GPIO_WIDTH-1:0]        dir_sh;     // DIR bus value as last written

    assign page   = bus_req.addr[`PERIPH_ADDR_WIDTH-1:`PERIPH_VA_WIDTH];
    assign off    = bus_req.addr[`PERIPH_VA_WIDTH-1:0];
    assign legal  = (bus_req.acc == `BUS_ACC_4B) &&
                    ((page == `PAGE_GPIO && (off == 8'h00 || off == 8'h04)) ||
                     (page == `PAGE_TIMER &&
                      (off == 8'h00 || off == 8'h04 || off == 8'h08)));
    assign good   = bus_req.valid && legal;
    assign tmr_wr = good && bus_req.w_rb && (page == `PAGE_TIMER);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cmp_sh   <= '0;
            dir_sh   <= '0;
            quiet    <= 1'b0;
            tmr_wr_q <= 1'b0;
            gap      <= '0;
        end else begin
            tmr_wr_q <= tmr_wr;
            gap      <= timer_irq ? `BUS_WIDTH'(1) : gap + 1'b1;
            if (tmr_wr) begin
                quiet <= 1'b0;
                if (off == 8'h08) cmp_sh <= bus_req.wdata;
            end else if (timer_irq && !tmr_wr_q) begin
                quiet <= 1'b1;
            end
            if (good && bus_req.w_rb && page == `PAGE_GPIO && off == 8'h04) begin
                dir_sh <= bus_req.wdata[`GPIO_WIDTH-1:0];
            end
        end
    end

    // reset state
    a_reset: assert property (@(posedge clk) !rstn |=> (gpio_dir == dir_in && gpio_o == '0
        && !bus_rsp.resp && !timer_irq)) else $error("reset state wrong");

    // response timing
    a_resp: assert property (@(posedge clk) disable iff (!rstn) good |=> bus_rsp.resp)
        else $error("missing response");
    a_no_resp: assert property (@(posedge clk) disable iff (!rstn) !good |=> !bus_rsp.resp)
        else $error("response without a good request");
    a_fault_valid: assert property (@(posedge clk) disable iff (!rstn)
        !bus_req.valid |-> !bus_rsp.fault) else $error("fault without request");
    a_no_fault: assert property (@(posedge clk) disable iff (!rstn)
        good |-> !bus_rsp.fault) else $error("mapped word access faulted");

    // fault rules
    a_fault_acc: assert property (@(posedge clk) disable iff (!rstn)
        bus_req.valid && bus_req.acc != `BUS_ACC_4B |-> bus_rsp.fault)
        else $error("bad access size not faulted");
    a_fault_page: assert property (@(posedge clk) disable iff (!rstn)
        bus_req.valid && page != `PAGE_GPIO && page != `PAGE_TIMER |-> bus_rsp.fault)
        else $error("unmapped page not faulted");
    a_fault_gpio_off: assert property (@(posedge clk) disable iff (!rstn)
        bus_req.valid && page == `PAGE_GPIO && off != 8'h00 && off != 8'h04
        |-> bus_rsp.fault) else $error("unmapped gpio offset not faulted");
    a_fault_tmr_off: assert property (@(posedge clk) disable iff (!rstn)
        bus_req.valid && page == `PAGE_TIMER && off != 8'h00 && off != 8'h04 && off != 8'h08
        |-> bus_rsp.fault) else $error("unmapped timer offset not faulted");
    a_fault_state: assert property (@(posedge clk) disable iff (!rstn)
        bus_rsp.fault |=> $stable(gpio_o) && $stable(gpio_dir))
        else $error("faulting request changed gpio state");

    // gpio registers
    a_d_wr: assert property (@(posedge clk) disable iff (!rstn)
        good && bus_req.w_rb && page == `PAGE_GPIO && off == 8'h00
        |=> gpio_o == $past(bus_req.wdata[`GPIO_WIDTH-1:0])) else $error("D write wrong");
    a_dir_wr: assert property (@(posedge clk) disable iff (!rstn)
        good && bus_req.w_rb && page == `PAGE_GPIO && off == 8'h04
        |=> gpio_dir == ($past(bus_req.wdata[`GPIO_WIDTH-1:0]) ^ dir_in))
        else $error("DIR write wrong");
    a_d_rd: assert property (@(posedge clk) disable iff (!rstn)
        good && !bus_req.w_rb && page == `PAGE_GPIO && off == 8'h00
        |=> bus_rsp.rdata == `BUS_WIDTH'($past(gpio_i))) else $error("D read wrong");
    a_dir_rd: assert property (@(posedge clk) disable iff (!rstn)
        good && !bus_req.w_rb && page == `PAGE_GPIO && off == 8'h04
        |=> bus_rsp.rdata == `BUS_WIDTH'($past(dir_sh))) else $error("DIR read wrong");

    // timer
    a_irq_period: assert property (@(posedge clk) disable iff (!rstn)
        timer_irq && quiet |-> gap == cmp_sh + 1'b1) else $error("timer period wrong");
    a_count_rd: assert property (@(posedge clk) disable iff (!rstn)
        good && !bus_req.w_rb && page == `PAGE_TIMER && off == 8'h04 && quiet
        |=> bus_rsp.rdata <= cmp_sh) else $error("COUNT read above compare");

endmodule

bind periph_top periph_assert i_periph_assert (
    .clk       (clk),
    .rstn      (rstn),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_dir  (gpio_dir),
    .timer_irq (timer_irq)
);

//--- testbench/periph_tb.sv
`include "periph_settings.svh"

module periph_tb
    import periph_pkg::*;
;

    localparam int n_random    = 300;
    localparam int n_directed  = 60;
    localparam int n_timer     = 120;
    localparam int cycle_limit = 2 * (n_directed + n_timer + n_random) + 100;

    logic                   clk;
    logic                   rstn;
    bus_req_t               bus_req;
    bus_rsp_t               bus_rsp;
    logic [`GPIO_WIDTH-1:0] gpio_i;
    logic [`GPIO_WIDTH-1:0] gpio_o;
    logic [`GPIO_WIDTH-1:0] gpio_dir;
    logic                   timer_irq;

    int cycles;
    int errors;
    int unreached;
    int hit_fault_acc, hit_fault_off, hit_fault_page;
    int hit_d_wr, hit_dir_wr, hit_d_rd, hit_dir_rd;
    int hit_irq, hit_cnt_rd, hit_b2b;
    logic prev_good;

    logic [`PERIPH_ADDR_WIDTH-1:0] addr_pool [9] = '{12'h000, 12'h004, 12'h008, 12'h100,
        12'h104, 12'h108, 12'h10c, 12'h200, 12'hf04};

    periph_top i_periph_top (
        .clk       (clk),
        .rstn      (rstn),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_dir  (gpio_dir),
        .timer_irq (timer_irq)
    );

    always #10 clk = ~clk;

    task automatic drive_req(input logic [`PERIPH_ADDR_WIDTH-1:0] addr, input logic w,
                             input logic [`BUS_ACC_WIDTH-1:0] acc,
                             input logic [`BUS_WIDTH-1:0] data);
        bus_req_t r;
        r.valid = 1'b1;
        r.addr  = addr;
        r.w_rb  = w;
        r.acc   = acc;
        r.wdata = data;
        @(posedge clk);
        bus_req <= r;
    endtask

    task automatic idle_bus(input int n);
        @(posedge clk);
        bus_req.valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic check_hit(input string name, input int n);
        if (n == 0) begin
            $display("check never reached by the stimulus: %s", name);
            unreached++;
        end
    endtask

    // watch the bus as the DUT sees it
    always @(posedge clk) begin
        if (rstn) begin
            if (bus_req.valid && bus_rsp.fault) begin
                if (bus_req.acc != `BUS_ACC_4B) hit_fault_acc++;
                else if (bus_req.addr[11:8] > 1) hit_fault_page++;
                else hit_fault_off++;
            end
            if (bus_req.valid && !bus_rsp.fault) begin
                case ({bus_req.addr, bus_req.w_rb})
                    {12'h000, 1'b1}: hit_d_wr++;
                    {12'h004, 1'b1}: hit_dir_wr++;
                    {12'h000, 1'b0}: hit_d_rd++;
                    {12'h004, 1'b0}: hit_dir_rd++;
                    {12'h104, 1'b0}: hit_cnt_rd++;
                    default: ;
                endcase
                if (prev_good) hit_b2b++;
            end
            if (timer_irq) hit_irq++;
            prev_good <= bus_req.valid && !bus_rsp.fault;
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            errors++;
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        bus_req   = '0;
        gpio_i    = '0;
        prev_good = 1'b0;
        void'($urandom(32'h64e7a5a3));
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        idle_bus(1);

        // gpio registers, back to back
        gpio_i <= 16'h3c5a;
        drive_req(12'h000, 1'b1, `BUS_ACC_4B, 32'hdead_a5a5);
        drive_req(12'h004, 1'b1, `BUS_ACC_4B, 32'h0000_00ff);
        drive_req(12'h000, 1'b0, `BUS_ACC_4B, 32'h0);
        drive_req(12'h004, 1'b0, `BUS_ACC_4B, 32'h0);
        idle_bus(2);

        // faults leave state alone
        drive_req(12'h000, 1'b1, `BUS_ACC_1B, 32'h1111);
        drive_req(12'h008, 1'b1, `BUS_ACC_4B, 32'h2222);
        drive_req(12'h200, 1'b1, `BUS_ACC_4B, 32'h3333);
        drive_req(12'h004, 1'b1, `BUS_ACC_2B, 32'h4444);
        idle_bus(2);

        // timer with compare 5
        drive_req(12'h108, 1'b1, `BUS_ACC_4B, 32'd5);
        drive_req(12'h100, 1'b1, `BUS_ACC_4B, 32'd1);
        idle_bus(0);
        while (hit_irq < 2) @(negedge clk);
        repeat (6) begin
            drive_req(12'h104, 1'b0, `BUS_ACC_4B, 32'h0);
            idle_bus(0);
        end
        while (hit_irq < 5) @(negedge clk);
        drive_req(12'h100, 1'b1, `BUS_ACC_4B, 32'd0);
        idle_bus(2);

        // random burst, one request per cycle
        for (int i = 0; i < n_random; i++) begin
            gpio_i <= `GPIO_WIDTH'($urandom());
            drive_req(addr_pool[4'($urandom() % 9)], 1'($urandom()),
                      ($urandom() % 8 == 0) ? `BUS_ACC_WIDTH'($urandom()) : `BUS_ACC_4B,
                      $urandom());
        end
        idle_bus(3);

        check_hit("bad access size fault", hit_fault_acc);
        check_hit("unmapped offset fault", hit_fault_off);
        check_hit("unmapped page fault", hit_fault_page);
        check_hit("D write", hit_d_wr);
        check_hit("DIR write", hit_dir_wr);
        check_hit("D read", hit_d_rd);
        check_hit("DIR read", hit_dir_rd);
        check_hit("timer irq", hit_irq);
        check_hit("COUNT read", hit_cnt_rd);
        check_hit("back to back requests", hit_b2b);
        errors += unreached;

        $display("errors: %0d total, %0d unreached checks, %0d cycles",
                 errors, unreached, cycles);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- periph_bus.f
+incdir+src
src/periph_pkg.sv
src/periph_decoder.sv
src/gpio_controller.sv
src/interval_timer.sv
src/periph_top.sv
testbench/periph_assert.sv
testbench/periph_tb.sv

//--- Makefile
SRCS := $(wildcard src/*.sv src/*.svh testbench/*.sv) periph_bus.f

.PHONY: all run clean

all: run

obj_dir/Vperiph_tb: $(SRCS)
	verilator --binary --timing --assert -f periph_bus.f --top-module periph_tb -o Vperiph_tb

run: obj_dir/Vperiph_tb
	./obj_dir/Vperiph_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
